/* dv/core_assertions.sv */
`include "core_macros.svh"

module core_assertions (
    input logic                  clk,
    input logic                  resetn,
    input logic                  push_i,
    input logic                  pop_i,
    input logic                  full_i,
    input logic                  not_empty_i,
    input logic                  imem_req_i,
    input logic                  commit_valid_i,
    input logic [`CORE_XLEN-1:0] commit_pc_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // pc of the previous commit, valid once one has retired
    logic                  seen_q;
    logic [`CORE_XLEN-1:0] last_pc_q;

    // assertion failures seen by this instance
    int unsigned           fail_count = 0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            seen_q <= 1'b0;
        end else if (commit_valid_i) begin
            seen_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_valid_i) begin
            last_pc_q <= commit_pc_i;
        end
    end

    // ======================================
    // fifo
    // ======================================

    no_push_when_full: assert property (
        @(posedge clk) disable iff (!resetn) push_i |-> !full_i
    ) else begin
        $error("push into a full instruction FIFO");
        fail_count++;
    end

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!resetn) pop_i |-> not_empty_i
    ) else begin
        $error("pop from an empty instruction FIFO");
        fail_count++;
    end

    // ======================================
    // core
    // ======================================

    quiet_after_reset: assert property (
        @(posedge clk) $rose(resetn) |-> (!imem_req_i && !commit_valid_i)
    ) else begin
        $error("request or commit in the first cycle after reset");
        fail_count++;
    end

    // straight-line program, no redirection
    commit_pc_step: assert property (
        @(posedge clk) disable iff (!resetn)
        (commit_valid_i && seen_q) |-> (commit_pc_i == last_pc_q + 4)
    ) else begin
        $error("commit pc does not follow the previous commit by four");
        fail_count++;
    end

endmodule

bind instr_fifo core_assertions u_fifo_checks (
    .clk            (clk),
    .resetn         (resetn),
    .push_i         (push_i),
    .pop_i          (pop_i),
    .full_i         (count_q == CNT_W'(DEPTH)),
    .not_empty_i    (not_empty_o),
    .imem_req_i     (1'b0),
    .commit_valid_i (1'b0),
    .commit_pc_i    ('0)
);

bind core_top core_assertions u_core_checks (
    .clk            (clk),
    .resetn         (resetn),
    .push_i         (1'b0),
    .pop_i          (1'b0),
    .full_i         (1'b0),
    .not_empty_i    (1'b0),
    .imem_req_i     (imem_req_o),
    .commit_valid_i (commit_valid_o),
    .commit_pc_i    (commit_o.pc)
);

/* dv/core_tb.sv */
`include "core_macros.svh"

module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int PROG_WORDS  = 2048;
    localparam int NUM_COMMITS = 2000;
    localparam int CYCLE_LIMIT = 4 * NUM_COMMITS + 100;

    logic                  clk = 1'b0;
    logic                  resetn;
    logic [`CORE_XLEN-1:0] imem_data;
    logic                  imem_req;
    logic [`CORE_XLEN-1:0] imem_addr;
    logic                  commit_valid;
    commit_t               commit;

    logic [`CORE_XLEN-1:0] prog [PROG_WORDS];
    logic [`CORE_XLEN-1:0] model_regs [32];
    logic [`CORE_XLEN-1:0] model_pc = `CORE_RESET_PC;
    logic [31:0]           lfsr_q = 32'h5b66_7ac3;
    int                    n_commits = 0;
    int                    cycles = 0;
    bit                    first_req_seen = 1'b0;

    core_top dut (
        .clk            (clk),
        .resetn         (resetn),
        .imem_data_i    (imem_data),
        .imem_req_o     (imem_req),
        .imem_addr_o    (imem_addr),
        .commit_valid_o (commit_valid),
        .commit_o       (commit)
    );

    always #10 clk = ~clk;

    // ========================================
    // stimulus
    // ========================================

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    // mostly x0..x7 so dependences are common
    function automatic logic [4:0] pick_reg();
        logic [4:0] r;
        r = 5'(next_bits(5));
        return (r < 5'd24) ? {2'b00, r[2:0]} : r;
    endfunction

    function automatic logic [31:0] make_instr();
        logic [2:0]  fmt;
        logic [2:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [9:0]  f7_f3;
        if (next_bits(4) == 32'd0) begin
            return next_bits(32);
        end
        fmt = 3'(next_bits(3));
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        case (fmt)
            3'd3, 3'd4, 3'd5: begin
                // funct3 taken raw, shifts and sltiu come out illegal
                sel = 3'(next_bits(3));
                return {12'(next_bits(12)), rs1, sel, rd, 7'h13};
            end
            3'd6: return {20'(next_bits(20)), rd, 7'h37};
            default: begin
                sel = 3'(next_bits(3));
                case (sel)
                    3'd0:    f7_f3 = {7'h00, 3'b000};
                    3'd1:    f7_f3 = {7'h20, 3'b000};
                    3'd2:    f7_f3 = {7'h00, 3'b111};
                    3'd3:    f7_f3 = {7'h00, 3'b110};
                    3'd4:    f7_f3 = {7'h00, 3'b100};
                    3'd5:    f7_f3 = {7'h00, 3'b010};
                    3'd6:    f7_f3 = {7'h00, 3'b001};
                    default: f7_f3 = {7'h00, 3'b101};
                endcase
                return {f7_f3[9:3], rs2, rs1, f7_f3[2:0], rd, 7'h33};
            end
        endcase
    endfunction

    // ========================================
    // reference model
    // ========================================

    function automatic commit_t predict_commit(input logic [31:0] pc, input logic [31:0] ins);
        commit_t     c;
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        c.pc      = pc;
        c.instr   = ins;
        c.rd      = ins[11:7];
        c.wdata   = '0;
        c.illegal = 1'b0;
        a  = model_regs[ins[19:15]];
        f3 = ins[14:12];
        if (ins[6:0] == 7'h33) begin
            b = model_regs[ins[24:20]];
            if (ins[31:25] == 7'h20 && f3 == 3'b000) begin
                c.wdata = a - b;
            end else if (ins[31:25] != 7'h00 || f3 == 3'b011) begin
                c.illegal = 1'b1;
            end else begin
                case (f3)
                    3'b000:  c.wdata = a + b;
                    3'b001:  c.wdata = a << b[4:0];
                    3'b010:  c.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100:  c.wdata = a ^ b;
                    3'b101:  c.wdata = a >> b[4:0];
                    3'b110:  c.wdata = a | b;
                    default: c.wdata = a & b;
                endcase
            end
        end else if (ins[6:0] == 7'h13) begin
            b = {{20{ins[31]}}, ins[31:20]};
            case (f3)
                3'b000:  c.wdata = a + b;
                3'b010:  c.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100:  c.wdata = a ^ b;
                3'b110:  c.wdata = a | b;
                3'b111:  c.wdata = a & b;
                default: c.illegal = 1'b1;
            endcase
        end else if (ins[6:0] == 7'h37) begin
            c.wdata = {ins[31:12], 12'h000};
        end else begin
            c.illegal = 1'b1;
        end
        c.we = !c.illegal && (c.rd != 5'd0);
        return c;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // failures counted by both bound checkers
    function automatic int unsigned bound_failures();
        return dut.u_core_checks.fail_count + dut.u_fifo.u_fifo_checks.fail_count;
    endfunction

    // ========================================
    // instruction memory and monitors
    // ========================================

    always @(posedge clk) begin
        if (imem_req) begin
            if (!first_req_seen) begin
                check_field("imem_addr_o", `CORE_RESET_PC, imem_addr);
                first_req_seen = 1'b1;
            end
            imem_data <= prog[imem_addr[12:2]];
        end
    end

    always @(negedge clk) begin : commit_monitor
        commit_t exp;
        if (resetn && commit_valid) begin
            exp = predict_commit(model_pc, prog[model_pc[12:2]]);
            check_field("commit_o.pc", exp.pc, commit.pc);
            check_field("commit_o.instr", exp.instr, commit.instr);
            check_field("commit_o.rd", 32'(exp.rd), 32'(commit.rd));
            check_field("commit_o.illegal", 32'(exp.illegal), 32'(commit.illegal));
            check_field("commit_o.we", 32'(exp.we), 32'(commit.we));
            if (!exp.illegal) begin
                check_field("commit_o.wdata", exp.wdata, commit.wdata);
            end
            if (exp.we) begin
                model_regs[exp.rd] = exp.wdata;
            end
            model_pc  = model_pc + 4;
            n_commits = n_commits + 1;
        end
    end

    always @(negedge clk) begin
        assert (bound_failures() == 0)
        else begin
            $display("a bound assertion on the FIFO or commit port failed at %0t ns", $time);
            $display("TESTS FAILED");
            $fatal(1, "bound assertion failure");
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, %0d of %0d instructions committed in %0d cycles",
                     n_commits, NUM_COMMITS, cycles);
            $display("TESTS FAILED");
            $fatal(1, "run did not finish in time");
        end
    end

    initial begin
        resetn    = 1'b0;
        imem_data = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = make_instr();
        end
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        // first cycle out of reset is quiet
        @(negedge clk);
        check_field("imem_req_o", 32'd0, 32'(imem_req));
        check_field("commit_valid_o", 32'd0, 32'(commit_valid));
        wait (n_commits == NUM_COMMITS);
        if (bound_failures() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("a bound assertion on the FIFO or commit port failed during the run");
            $display("TESTS FAILED");
            $fatal(1, "bound assertion failure");
        end
    end

endmodule

/* hdl/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// register and data path width
`define CORE_XLEN 32

// default instruction FIFO entries
`define CORE_FIFO_DEPTH 4

// address of the first fetch after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

/* hdl/core_pkg.sv */
`include "core_macros.svh"

package core_pkg;

    // ======================================
    // fetch to execute
    // ======================================

    // one fetched word and the address it came from
    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] instr;
    } fetch_pkt_t;

    // ======================================
    // execute
    // ======================================

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        // lui, result is operand b
        ALU_PASS_B = 4'd8
    } alu_op_e;

    // retired instruction as seen on the commit port
    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] instr;
        logic [4:0]            rd;
        logic [`CORE_XLEN-1:0] wdata;
        logic                  we;
        logic                  illegal;
    } commit_t;

endpackage

/* hdl/core_top.sv */
`include "core_macros.svh"

module core_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [`CORE_XLEN-1:0] imem_data_i,
    output logic                  imem_req_o,
    output logic [`CORE_XLEN-1:0] imem_addr_o,
    output logic                  commit_valid_o,
    output core_pkg::commit_t     commit_o
);

    import core_pkg::*;

    // fetch to fifo
    logic                  fifo_room;
    logic                  fifo_push;
    fetch_pkt_t            fifo_push_pkt;
    // fifo to execute
    fetch_pkt_t            fifo_head;
    logic                  fifo_not_empty;
    logic                  fifo_pop;
    // register file
    logic [4:0]            rf_raddr1;
    logic [4:0]            rf_raddr2;
    logic [`CORE_XLEN-1:0] rf_rdata1;
    logic [`CORE_XLEN-1:0] rf_rdata2;
    logic                  rf_we;
    logic [4:0]            rf_waddr;
    logic [`CORE_XLEN-1:0] rf_wdata;

    fetch_unit u_fetch (
        .clk         (clk),
        .resetn      (resetn),
        .room_i      (fifo_room),
        .imem_data_i (imem_data_i),
        .imem_req_o  (imem_req_o),
        .imem_addr_o (imem_addr_o),
        .push_o      (fifo_push),
        .pkt_o       (fifo_push_pkt)
    );

    instr_fifo #(
        .DEPTH (`CORE_FIFO_DEPTH)
    ) u_fifo (
        .clk         (clk),
        .resetn      (resetn),
        .push_i      (fifo_push),
        .pkt_i       (fifo_push_pkt),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .not_empty_o (fifo_not_empty),
        .room_o      (fifo_room)
    );

    exec_unit u_exec (
        .clk            (clk),
        .resetn         (resetn),
        .head_i         (fifo_head),
        .not_empty_i    (fifo_not_empty),
        .rdata1_i       (rf_rdata1),
        .rdata2_i       (rf_rdata2),
        .pop_o          (fifo_pop),
        .raddr1_o       (rf_raddr1),
        .raddr2_o       (rf_raddr2),
        .we_o           (rf_we),
        .waddr_o        (rf_waddr),
        .wdata_o        (rf_wdata),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    regfile u_regfile (
        .clk      (clk),
        .resetn   (resetn),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

endmodule

/* hdl/exec_unit.sv */
`include "core_macros.svh"

module exec_unit (
    input  logic                  clk,
    input  logic                  resetn,
    input  core_pkg::fetch_pkt_t  head_i,
    input  logic                  not_empty_i,
    input  logic [`CORE_XLEN-1:0] rdata1_i,
    input  logic [`CORE_XLEN-1:0] rdata2_i,
    output logic                  pop_o,
    output logic [4:0]            raddr1_o,
    output logic [4:0]            raddr2_o,
    output logic                  we_o,
    output logic [4:0]            waddr_o,
    output logic [`CORE_XLEN-1:0] wdata_o,
    output logic                  commit_valid_o,
    output core_pkg::commit_t     commit_o
);

    import core_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam int         SHAMT_W    = $clog2(`CORE_XLEN);

    logic [`CORE_XLEN-1:0] instr;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;

    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  illegal;
    logic [`CORE_XLEN-1:0] imm;

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] rs2_val;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] alu_res;

    commit_t               wb_d;
    commit_t               wb_q;
    logic                  valid_q;

    // never stalls, bypass covers every dependence
    assign pop_o = not_empty_i;

    // ======================================
    // decode
    // ======================================

    assign instr  = head_i.instr;
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    always_comb begin
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        illegal = 1'b0;
        imm     = {{(`CORE_XLEN - 12){instr[31]}}, instr[31:20]};
        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  alu_op = ALU_ADD;
                        3'b001:  alu_op = ALU_SLL;
                        3'b010:  alu_op = ALU_SLT;
                        3'b100:  alu_op = ALU_XOR;
                        3'b101:  alu_op = ALU_SRL;
                        3'b110:  alu_op = ALU_OR;
                        3'b111:  alu_op = ALU_AND;
                        default: illegal = 1'b1;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    alu_op = ALU_SUB;
                end else begin
                    illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                // no immediate shifts or sltiu
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: illegal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                alu_op  = ALU_PASS_B;
                use_imm = 1'b1;
                imm     = {instr[31:12], 12'b0};
            end
            default: illegal = 1'b1;
        endcase
    end

    // ======================================
    // operands and alu
    // ======================================

    assign raddr1_o = rs1;
    assign raddr2_o = rs2;

    // we_o already excludes x0
    assign op_a    = (we_o && waddr_o == rs1) ? wdata_o : rdata1_i;
    assign rs2_val = (we_o && waddr_o == rs2) ? wdata_o : rdata2_i;
    assign op_b    = use_imm ? imm : rs2_val;

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(`CORE_XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_res = op_a << op_b[SHAMT_W-1:0];
            ALU_SRL:    alu_res = op_a >> op_b[SHAMT_W-1:0];
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // ======================================
    // writeback and commit
    // ======================================

    always_comb begin
        wb_d.pc      = head_i.pc;
        wb_d.instr   = instr;
        wb_d.rd      = rd;
        wb_d.wdata   = illegal ? '0 : alu_res;
        wb_d.we      = !illegal && (rd != 5'd0);
        wb_d.illegal = illegal;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop_o;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            wb_q <= wb_d;
        end
    end

    // register write lands at the end of the commit cycle
    assign we_o           = valid_q & wb_q.we;
    assign waddr_o        = wb_q.rd;
    assign wdata_o        = wb_q.wdata;
    assign commit_valid_o = valid_q;
    assign commit_o       = wb_q;

endmodule

/* hdl/fetch_unit.sv */
`include "core_macros.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  room_i,
    input  logic [`CORE_XLEN-1:0] imem_data_i,
    output logic                  imem_req_o,
    output logic [`CORE_XLEN-1:0] imem_addr_o,
    output logic                  push_o,
    output core_pkg::fetch_pkt_t  pkt_o
);

    localparam logic [`CORE_XLEN-1:0] INSTR_BYTES = 4;

    // high from the first cycle after reset is released
    logic                  run_q;
    logic [`CORE_XLEN-1:0] pc_q;
    // request sent last cycle, word arrives now
    logic                  pend_q;
    logic [`CORE_XLEN-1:0] pend_addr_q;

    // ======================================
    // request side
    // ======================================

    // room_i guarantees space for this request and the one in flight
    assign imem_req_o  = run_q & room_i;
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            run_q  <= 1'b0;
            pc_q   <= `CORE_RESET_PC;
            pend_q <= 1'b0;
        end else begin
            run_q  <= 1'b1;
            pend_q <= imem_req_o;
            if (imem_req_o) begin
                pc_q <= pc_q + INSTR_BYTES;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req_o) begin
            pend_addr_q <= pc_q;
        end
    end

    // ======================================
    // push side
    // ======================================

    // memory answers one cycle after the request
    assign push_o      = pend_q;
    assign pkt_o.pc    = pend_addr_q;
    assign pkt_o.instr = imem_data_i;

endmodule

/* hdl/instr_fifo.sv */
`include "core_macros.svh"

module instr_fifo #(
    parameter int DEPTH = `CORE_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 push_i,
    input  core_pkg::fetch_pkt_t pkt_i,
    input  logic                 pop_i,
    output core_pkg::fetch_pkt_t head_o,
    output logic                 not_empty_o,
    output logic                 room_o
);

    import core_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_pkt_t       mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // wrap explicitly, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ======================================
    // pointers and occupancy
    // ======================================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= pkt_i;
        end
    end

    assign head_o      = mem_q[rd_ptr_q];
    assign not_empty_o = (count_q != '0);
    // two free slots, one for a request already in flight
    assign room_o      = (count_q <= CNT_W'(DEPTH - 2));

endmodule

/* hdl/regfile.sv */
`include "core_macros.svh"

module regfile (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [4:0]            raddr1_i,
    input  logic [4:0]            raddr2_i,
    input  logic                  we_i,
    input  logic [4:0]            waddr_i,
    input  logic [`CORE_XLEN-1:0] wdata_i,
    output logic [`CORE_XLEN-1:0] rdata1_o,
    output logic [`CORE_XLEN-1:0] rdata2_o
);

    logic [`CORE_XLEN-1:0] regs_q [32];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs_q[raddr2_i];

endmodule

/* project.f */
+incdir+hdl
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/instr_fifo.sv
hdl/regfile.sv
hdl/exec_unit.sv
hdl/core_top.sv
dv/core_assertions.sv
dv/core_tb.sv
